// File: filelist.f
+incdir+hw
hw/raster_geom_pkg.sv
hw/raster_ctrl_pkg.sv
hw/tri_setup.sv
hw/pixel_walker.sv
hw/edge_eval.sv
hw/frag_out.sv
hw/raster_ctrl.sv
hw/rasterizer.sv
tests/raster_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the rasterizer testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module raster_tb -f filelist.f -o raster_sim
./obj_dir/raster_sim 2>&1 | tee sim.log

if grep -qx "test passed" sim.log; then
    echo "simulation PASS"
    exit 0
else
    echo "simulation FAIL"
    exit 1
fi

// File: tests/raster_tb.sv
`timescale 1ns/1ns
`include "raster_cfg.svh"

module raster_tb;
    import raster_geom_pkg::*;

    localparam int NUM_ROWS  = 6;
    localparam int TRI_LIMIT = 20000;   // cycles allowed per triangle

    typedef struct packed {
        vertex_t                       a;
        vertex_t                       b;
        vertex_t                       c;
        logic [`RASTER_FRAC_BITS-1:0]  frac;    // fraction added to every coordinate
        addr_t                         base;
        logic                          last;
        logic [1:0]                    stall;   // stall when two random bits are below this
    } row_t;

    logic        clock;
    logic        reset;
    vertex_fix_t v1;
    vertex_fix_t v2;
    vertex_fix_t v3;
    addr_t       addr_in;
    logic        in_data_valid;
    logic        done_in;
    logic        stall_in;
    addr_t       addr_out;
    logic        output_valid;
    logic        stall_out;
    logic        done_out;

    row_t        rows [NUM_ROWS];
    addr_t       exp_q [$];         // expected fragment addresses in scan order
    logic [31:0] lfsr;

    rasterizer i_dut (.*);

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    function automatic row_t make_row(int ax, int ay, int bx, int by, int cx, int cy,
                                      logic [`RASTER_FRAC_BITS-1:0] frac, addr_t base,
                                      logic last, logic [1:0] stall);
        row_t r;
        r.a     = '{x: coord_t'(ax), y: coord_t'(ay)};
        r.b     = '{x: coord_t'(bx), y: coord_t'(by)};
        r.c     = '{x: coord_t'(cx), y: coord_t'(cy)};
        r.frac  = frac;
        r.base  = base;
        r.last  = last;
        r.stall = stall;
        return r;
    endfunction

    function automatic vertex_fix_t to_fix(vertex_t v, logic [`RASTER_FRAC_BITS-1:0] frac);
        return '{x: fix_t'({v.x, frac}), y: fix_t'({v.y, frac})};
    endfunction

    // cross product of a->b with a->p that is zero on the edge itself
    function automatic longint edge_fn(int ax, int ay, int bx, int by, int px, int py);
        return longint'(px - ax) * longint'(by - ay) - longint'(py - ay) * longint'(bx - ax);
    endfunction

    task automatic build_expected(input row_t r);
        int xs [3];
        int ys [3];
        int min_x;
        int max_x;
        int min_y;
        int max_y;
        exp_q.delete();
        xs = '{int'(r.a.x), int'(r.b.x), int'(r.c.x)};
        ys = '{int'(r.a.y), int'(r.b.y), int'(r.c.y)};
        min_x = xs[0];
        max_x = xs[0];
        min_y = ys[0];
        max_y = ys[0];
        for (int i = 1; i < 3; i++) begin
            if (xs[i] < min_x) min_x = xs[i];
            if (xs[i] > max_x) max_x = xs[i];
            if (ys[i] < min_y) min_y = ys[i];
            if (ys[i] > max_y) max_y = ys[i];
        end
        for (int y = min_y; y <= max_y; y++) begin
            for (int x = min_x; x <= max_x; x++) begin
                if (edge_fn(xs[0], ys[0], xs[1], ys[1], x, y) >= 0 &&
                    edge_fn(xs[1], ys[1], xs[2], ys[2], x, y) >= 0 &&
                    edge_fn(xs[2], ys[2], xs[0], ys[0], x, y) >= 0)
                    exp_q.push_back(r.base +
                        addr_t'((y * `RASTER_SCREEN_W + x) << `RASTER_PIX_SHIFT));
            end
        end
    endtask

    task automatic fail_with(string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic compare(string name, longint got, longint exp);
        if (got != exp)
            fail_with($sformatf("Mismatch at %0t ns: %s got 0x%0h, expected 0x%0h",
                                $time, name, got, exp));
    endtask

    task automatic run_triangle(input row_t r);
        int    cycles;
        int    consumed;
        int    dones;
        logic  held;
        logic  seen_idle;
        addr_t held_addr;
        logic  b0;
        logic  b1;

        build_expected(r);
        v1            = to_fix(r.a, r.frac);
        v2            = to_fix(r.b, r.frac);
        v3            = to_fix(r.c, r.frac);
        addr_in       = r.base;
        done_in       = r.last;
        in_data_valid = 1'b1;
        @(negedge clock);                   // accepted on the rising edge in between
        compare("stall_out", stall_out, 1'b1);
        cycles    = 0;
        consumed  = 0;
        dones     = 0;
        held      = 1'b0;
        seen_idle = 1'b0;
        held_addr = '0;
        forever begin
            if (held) begin                 // stalled fragment must not move
                compare("output_valid", output_valid, 1'b1);
                compare("addr_out", addr_out, held_addr);
            end
            if (seen_idle)
                compare("stall_out", stall_out, 1'b0);
            // back in idle only with every fragment consumed or loaded
            if (!stall_out && !seen_idle)
                compare("fragments at stall_out fall", consumed + int'(output_valid),
                        exp_q.size());
            if (done_out) begin
                dones++;
                compare("fragments at done_out", consumed + int'(output_valid), exp_q.size());
            end
            lfsr     = lfsr_step(lfsr);
            b0       = lfsr[0];
            lfsr     = lfsr_step(lfsr);
            b1       = lfsr[0];
            stall_in = ({b1, b0} < r.stall);
            if (stall_out) begin
                // reversed copy offered while busy that must be ignored
                lfsr          = lfsr_step(lfsr);
                in_data_valid = lfsr[0];
                v2            = to_fix(r.c, r.frac);
                v3            = to_fix(r.b, r.frac);
                addr_in       = ~r.base;
                done_in       = ~r.last;
            end else begin
                in_data_valid = 1'b0;
            end
            if (output_valid && !stall_in) begin
                if (consumed >= exp_q.size())
                    fail_with("DUT emitted more fragments than the triangle covers");
                compare("addr_out", addr_out, exp_q[consumed]);
                consumed++;
            end
            held      = output_valid && stall_in;
            held_addr = addr_out;
            seen_idle = !stall_out;
            if (!stall_out && !output_valid)
                break;
            @(negedge clock);
            cycles++;
            if (cycles > TRI_LIMIT)
                fail_with("timeout: triangle did not finish");
        end
        compare("fragment count", consumed, exp_q.size());
        compare("done_out pulses", dones, r.last);
    endtask

    initial begin
        int cycles;

        reset         = 1'b0;
        v1            = '0;
        v2            = '0;
        v3            = '0;
        addr_in       = '0;
        in_data_valid = 1'b0;
        done_in       = 1'b0;
        stall_in      = 1'b0;
        lfsr          = 32'h30e7_3c45;

        rows[0] = make_row(10, 20, 10, 24, 14, 20, 16'h0000, 26'h000_1000, 1'b0, 2'd0);
        rows[1] = make_row(100, 100, 100, 100, 100, 100, 16'h8000, 26'h0, 1'b1, 2'd2);
        rows[2] = make_row(10, 20, 14, 20, 10, 24, 16'h0000, 26'h001_0000, 1'b1, 2'd1);
        rows[3] = make_row(200, 50, 200, 58, 210, 50, 16'h4000, 26'h002_0000, 1'b1, 2'd3);
        rows[4] = make_row(400, 300, 395, 306, 408, 304, 16'hffff, 26'h004_0000, 1'b0, 2'd2);
        rows[5] = make_row(630, 470, 630, 479, 639, 470, 16'h0000, 26'h0, 1'b1, 2'd1);

        repeat (10) @(negedge clock);
        compare("stall_out", stall_out, 1'b1);
        reset = 1'b1;
        @(negedge clock);
        compare("output_valid", output_valid, 1'b0);
        compare("done_out", done_out, 1'b0);
        cycles = 0;
        while (stall_out) begin
            @(negedge clock);
            cycles++;
            if (cycles > 100)
                fail_with("stall_out stayed high after reset");
        end

        for (int i = 0; i < NUM_ROWS; i++)
            run_triangle(rows[i]);

        $display("test passed");
        $finish;
    end

endmodule

// File: hw/rasterizer.sv
`timescale 1ns/1ns

module rasterizer (
    input  logic                         clock,
    input  logic                         reset,
    input  raster_geom_pkg::vertex_fix_t v1,
    input  raster_geom_pkg::vertex_fix_t v2,
    input  raster_geom_pkg::vertex_fix_t v3,
    input  raster_geom_pkg::addr_t       addr_in,
    input  logic                         in_data_valid,
    input  logic                         done_in,
    input  logic                         stall_in,
    output raster_geom_pkg::addr_t       addr_out,
    output logic                         output_valid,
    output logic                         stall_out,
    output logic                         done_out
);
    import raster_geom_pkg::*;
    import raster_ctrl_pkg::*;

    tri_t   triangle;
    bbox_t  box;
    coord_t cur_x;
    coord_t cur_y;
    frag_t  frag;
    logic   capture;
    logic   start;
    logic   step;
    logic   last;
    logic   eval_in;
    logic   eval_valid;
    logic   is_inside;
    logic   load;
    logic   busy;

    tri_setup i_setup (
        .clock    (clock),
        .reset    (reset),
        .capture  (capture),
        .v1       (v1),
        .v2       (v2),
        .v3       (v3),
        .addr_in  (addr_in),
        .done_in  (done_in),
        .triangle (triangle),
        .box      (box)
    );

    pixel_walker i_walker (
        .clock (clock),
        .reset (reset),
        .start (start),
        .step  (step),
        .box   (box),
        .cur_x (cur_x),
        .cur_y (cur_y),
        .last  (last)
    );

    edge_eval i_edge (
        .clock      (clock),
        .reset      (reset),
        .eval_in    (eval_in),
        .px         (cur_x),
        .py         (cur_y),
        .triangle   (triangle),
        .eval_valid (eval_valid),
        .is_inside  (is_inside)
    );

    frag_out i_frag (
        .clock        (clock),
        .reset        (reset),
        .load         (load),
        .frag         (frag),
        .triangle     (triangle),
        .stall_in     (stall_in),
        .addr_out     (addr_out),
        .output_valid (output_valid),
        .busy         (busy)
    );

    raster_ctrl i_ctrl (
        .clock         (clock),
        .reset         (reset),
        .in_data_valid (in_data_valid),
        .last          (last),
        .cur_x         (cur_x),
        .cur_y         (cur_y),
        .eval_valid    (eval_valid),
        .is_inside     (is_inside),
        .busy          (busy),
        .triangle      (triangle),
        .capture       (capture),
        .start         (start),
        .step          (step),
        .eval_in       (eval_in),
        .load          (load),
        .frag          (frag),
        .stall_out     (stall_out),
        .done_out      (done_out)
    );

endmodule

// File: hw/raster_ctrl.sv
`timescale 1ns/1ns

module raster_ctrl (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    in_data_valid,
    input  logic                    last,
    input  raster_geom_pkg::coord_t cur_x,
    input  raster_geom_pkg::coord_t cur_y,
    input  logic                    eval_valid,
    input  logic                    is_inside,
    input  logic                    busy,
    input  raster_geom_pkg::tri_t   triangle,
    output logic                    capture,
    output logic                    start,
    output logic                    step,
    output logic                    eval_in,
    output logic                    load,
    output raster_ctrl_pkg::frag_t  frag,
    output logic                    stall_out,
    output logic                    done_out
);
    import raster_ctrl_pkg::*;

    ctrl_state_t state;
    ctrl_state_t next_state;
    logic        advance;       // current pixel is finished
    logic        finish;        // last pixel of the box is finished

    always_comb begin
        next_state = state;
        capture    = 1'b0;
        start      = 1'b0;
        step       = 1'b0;
        eval_in    = 1'b0;
        load       = 1'b0;
        advance    = 1'b0;
        finish     = 1'b0;

        case (state)
            IDLE: begin
                if (in_data_valid && !stall_out) begin
                    capture    = 1'b1;
                    next_state = SETUP;
                end
            end
            SETUP: begin
                start      = 1'b1;                  // walker takes the box minimum
                next_state = ISSUE;
            end
            ISSUE: begin
                eval_in    = 1'b1;
                next_state = EVAL;
            end
            EVAL: begin
                if (eval_valid) begin
                    if (is_inside)
                        next_state = EMIT;
                    else
                        advance = 1'b1;             // nothing to emit
                end
            end
            EMIT: begin
                if (!busy) begin
                    load    = 1'b1;
                    advance = 1'b1;
                end
            end
            default: next_state = IDLE;
        endcase

        // move on, or end the triangle at the bottom right corner
        if (advance) begin
            if (last) begin
                finish     = 1'b1;
                next_state = IDLE;
            end else begin
                step       = 1'b1;
                next_state = ISSUE;
            end
        end
    end

    assign frag = '{x: cur_x, y: cur_y};

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state     <= IDLE;
            stall_out <= 1'b1;                      // not ready until out of reset
            done_out  <= 1'b0;
        end else begin
            state     <= next_state;
            stall_out <= (next_state != IDLE);
            done_out  <= finish && triangle.last;   // one cycle pulse
        end
    end

endmodule

// File: hw/frag_out.sv
`timescale 1ns/1ns
`include "raster_cfg.svh"

module frag_out (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   load,
    input  raster_ctrl_pkg::frag_t frag,
    input  raster_geom_pkg::tri_t  triangle,
    input  logic                   stall_in,
    output raster_geom_pkg::addr_t addr_out,
    output logic                   output_valid,
    output logic                   busy
);
    import raster_geom_pkg::*;

    addr_t pix_idx;
    addr_t next_addr;

    // byte address of the pixel in the frame buffer
    always_comb begin
        pix_idx   = addr_t'(frag.y) * addr_t'(`RASTER_SCREEN_W) + addr_t'(frag.x);
        next_addr = triangle.base + (pix_idx << `RASTER_PIX_SHIFT);
    end

    always_ff @(posedge clock) begin
        if (load)
            addr_out <= next_addr;              // held while stalled
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset)
            output_valid <= 1'b0;
        else if (load)
            output_valid <= 1'b1;
        else if (!stall_in)
            output_valid <= 1'b0;               // consumed this cycle
    end

    // a held fragment that is not taken this cycle blocks the next one
    assign busy = output_valid && stall_in;

endmodule

// File: hw/edge_eval.sv
`timescale 1ns/1ns

module edge_eval (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    eval_in,
    input  raster_geom_pkg::coord_t px,
    input  raster_geom_pkg::coord_t py,
    input  raster_geom_pkg::tri_t   triangle,
    output logic                    eval_valid,
    output logic                    is_inside
);
    import raster_geom_pkg::*;

    vertex_t vtx    [3];
    edge_t   x_term [3];    // stage one products
    edge_t   y_term [3];
    edge_t   diff   [3];
    logic    s1_valid;
    logic    all_pos;

    // (p - org) * (hi - lo) on operands widened before the multiply
    function automatic edge_t term(coord_t p, coord_t org, coord_t hi, coord_t lo);
        edge_t dp;
        edge_t dv;
        dp = edge_t'(p) - edge_t'(org);
        dv = edge_t'(hi) - edge_t'(lo);
        return dp * dv;
    endfunction

    assign vtx[0] = triangle.v1;
    assign vtx[1] = triangle.v2;
    assign vtx[2] = triangle.v3;

    // edges 1-2, 2-3 and 3-1
    always_ff @(posedge clock) begin
        if (eval_in) begin
            for (int i = 0; i < 3; i++) begin
                x_term[i] <= term(px, vtx[i].x, vtx[(i + 1) % 3].y, vtx[i].y);
                y_term[i] <= term(py, vtx[i].y, vtx[(i + 1) % 3].x, vtx[i].x);
            end
        end
    end

    always_comb begin
        all_pos = 1'b1;
        for (int i = 0; i < 3; i++) begin
            diff[i] = x_term[i] - y_term[i];
            if (diff[i] < 0)
                all_pos = 1'b0;                 // outside this edge
        end
    end

    always_ff @(posedge clock) begin
        if (s1_valid)
            is_inside <= all_pos;               // on the edge counts as inside
    end

    // valid travels alongside the data
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            s1_valid   <= 1'b0;
            eval_valid <= 1'b0;
        end else begin
            s1_valid   <= eval_in;
            eval_valid <= s1_valid;
        end
    end

endmodule

// File: hw/pixel_walker.sv
`timescale 1ns/1ns

module pixel_walker (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    start,
    input  logic                    step,
    input  raster_geom_pkg::bbox_t  box,
    output raster_geom_pkg::coord_t cur_x,
    output raster_geom_pkg::coord_t cur_y,
    output logic                    last
);
    import raster_geom_pkg::*;

    coord_t next_x;
    coord_t next_y;

    // scan order is left to right, then down one row
    always_comb begin
        if (cur_x == box.max_x) begin
            next_x = box.min_x;                 // wrap to the next row
            next_y = cur_y + coord_t'(1);
        end else begin
            next_x = cur_x + coord_t'(1);
            next_y = cur_y;
        end
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            cur_x <= '0;
            cur_y <= '0;
        end else if (start) begin
            cur_x <= box.min_x;                 // top left corner of the box
            cur_y <= box.min_y;
        end else if (step) begin
            cur_x <= next_x;
            cur_y <= next_y;
        end
    end

    // bottom right corner ends the scan
    assign last = (cur_x == box.max_x) && (cur_y == box.max_y);

endmodule

// File: hw/tri_setup.sv
`timescale 1ns/1ns
`include "raster_cfg.svh"

module tri_setup (
    input  logic                         clock,
    input  logic                         reset,
    input  logic                         capture,
    input  raster_geom_pkg::vertex_fix_t v1,
    input  raster_geom_pkg::vertex_fix_t v2,
    input  raster_geom_pkg::vertex_fix_t v3,
    input  raster_geom_pkg::addr_t       addr_in,
    input  logic                         done_in,
    output raster_geom_pkg::tri_t        triangle,
    output raster_geom_pkg::bbox_t       box
);
    import raster_geom_pkg::*;

    vertex_t iv1;
    vertex_t iv2;
    vertex_t iv3;

    // arithmetic shift drops the fraction and keeps the sign
    function automatic coord_t to_int(fix_t f);
        return coord_t'(f >>> `RASTER_FRAC_BITS);
    endfunction

    function automatic coord_t min3(coord_t a, coord_t b, coord_t c);
        coord_t m;
        m = (a < b) ? a : b;
        return (m < c) ? m : c;
    endfunction

    function automatic coord_t max3(coord_t a, coord_t b, coord_t c);
        coord_t m;
        m = (a > b) ? a : b;
        return (m > c) ? m : c;
    endfunction

    always_comb begin
        iv1.x = to_int(v1.x);
        iv1.y = to_int(v1.y);
        iv2.x = to_int(v2.x);
        iv2.y = to_int(v2.y);
        iv3.x = to_int(v3.x);
        iv3.y = to_int(v3.y);
    end

    // held until the next accepted triangle
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            triangle <= '0;
            box      <= '0;
        end else if (capture) begin
            triangle <= '{v1: iv1, v2: iv2, v3: iv3, base: addr_in, last: done_in};
            box.min_x <= min3(iv1.x, iv2.x, iv3.x);
            box.min_y <= min3(iv1.y, iv2.y, iv3.y);
            box.max_x <= max3(iv1.x, iv2.x, iv3.x);
            box.max_y <= max3(iv1.y, iv2.y, iv3.y);
        end
    end

endmodule

// File: hw/raster_ctrl_pkg.sv
package raster_ctrl_pkg;

    // controller states
    typedef enum logic [2:0] {
        IDLE,   // waiting for a triangle
        SETUP,  // integer vertices and box being registered
        ISSUE,  // current pixel sent to the edge pipeline
        EVAL,   // waiting for the inside result
        EMIT    // covered pixel waiting for the output register
    } ctrl_state_t;

    // pixel handed from the controller to the output register
    typedef struct packed {
        raster_geom_pkg::coord_t x;
        raster_geom_pkg::coord_t y;
    } frag_t;

endpackage

// File: hw/raster_geom_pkg.sv
`include "raster_cfg.svh"

package raster_geom_pkg;

    // scalar widths
    typedef logic signed [`RASTER_FIX_W-1:0] fix_t;   // 16.16 fixed point
    typedef logic signed [`RASTER_FIX_W-`RASTER_FRAC_BITS-1:0] coord_t;
    typedef logic signed [2*(`RASTER_FIX_W-`RASTER_FRAC_BITS):0] edge_t;
    typedef logic [`RASTER_ADDR_W-1:0] addr_t;

    typedef struct packed {
        fix_t x;
        fix_t y;
    } vertex_fix_t;         // vertex as given at the input

    typedef struct packed {
        coord_t x;
        coord_t y;
    } vertex_t;             // vertex on the pixel grid

    typedef struct packed {
        vertex_t v1;
        vertex_t v2;
        vertex_t v3;
        addr_t   base;      // frame buffer base
        logic    last;      // last triangle of the frame
    } tri_t;

    typedef struct packed {
        coord_t min_x;
        coord_t min_y;
        coord_t max_x;
        coord_t max_y;
    } bbox_t;

endpackage

// File: hw/raster_cfg.svh
`ifndef RASTER_CFG_SVH
`define RASTER_CFG_SVH

// frame buffer geometry
`define RASTER_SCREEN_W   640   // pixels per row
`define RASTER_SCREEN_H   480   // rows

// input coordinates are signed 16.16
`define RASTER_FIX_W      32
`define RASTER_FRAC_BITS  16

// each pixel takes 8 bytes in the frame buffer
`define RASTER_PIX_SHIFT  3

// frame buffer byte address
`define RASTER_ADDR_W     26

`endif
